// ==== design/udma_lite_pkg.sv ====
// udma lite shared definitions: widths, register map, copy states and bus structs
package udma_lite_pkg;

    // bus and counter widths
    localparam int unsigned L2_ADDR_WIDTH  = 32;
    localparam int unsigned L2_DATA_WIDTH  = 32;
    localparam int unsigned APB_ADDR_WIDTH = 12;
    localparam int unsigned SIZE_WIDTH     = 16;

    // address step between consecutive words
    localparam logic [L2_ADDR_WIDTH-1:0] WORD_BYTES = L2_ADDR_WIDTH'(4);

    // register byte offsets
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SRC_ADDR = 12'h000;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_DST_ADDR = 12'h004;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_SIZE     = 12'h008;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL     = 12'h00C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS   = 12'h010;

    // copy sequence, one word in flight
    typedef enum logic [1:0] {
        IDLE,
        RD_REQ,
        RD_WAIT,
        WR_REQ
    } xfer_state_e;

    typedef struct packed {
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [L2_DATA_WIDTH-1:0]  pwdata;
        logic                      pwrite;
        logic                      psel;
        logic                      penable;
    } apb_req_t;

    typedef struct packed {
        logic [L2_DATA_WIDTH-1:0] prdata;
        logic                     pready;
        logic                     pslverr;
    } apb_rsp_t;

    // read only L2 port
    typedef struct packed {
        logic                     req;
        logic [L2_ADDR_WIDTH-1:0] addr;
    } l2_rd_req_t;

    typedef struct packed {
        logic                     gnt;
        logic                     rvalid;
        logic [L2_DATA_WIDTH-1:0] rdata;
    } l2_rd_rsp_t;

    // write only L2 port, full words
    typedef struct packed {
        logic                     req;
        logic [L2_ADDR_WIDTH-1:0] addr;
        logic [L2_DATA_WIDTH-1:0] wdata;
    } l2_wr_req_t;

    typedef struct packed {
        logic [L2_ADDR_WIDTH-1:0] src_addr;
        logic [L2_ADDR_WIDTH-1:0] dst_addr;
        logic [SIZE_WIDTH-1:0]    words;
    } xfer_cfg_t;

    // four bit peripheral event, upper bits unused here
    typedef struct packed {
        logic [1:0] rsvd;
        logic       cfg_err;
        logic       eot;
    } udma_evt_t;

endpackage

// ==== design/udma_cfg_regs.sv ====
// channel register file on APB with copy config, status, start pulse and events
`timescale 1ns/100ps

module udma_cfg_regs import udma_lite_pkg::*; (
    input  logic      sys_clk_i,
    input  logic      arst_n_i,
    input  apb_req_t  apb_req_i,
    output apb_rsp_t  apb_rsp_o,
    input  logic      busy_i,
    input  logic      done_i,
    output xfer_cfg_t cfg_o,
    output logic      start_o,
    output udma_evt_t evt_o
);

    logic                     access;
    logic                     decode;
    logic                     commit;
    logic                     ctrl_wr;
    logic                     hit;
    logic [L2_DATA_WIDTH-1:0] rd_data;
    logic                     pready_q;
    logic                     pslverr_q;
    logic [L2_DATA_WIDTH-1:0] prdata_q;
    logic [L2_ADDR_WIDTH-1:0] src_q;
    logic [L2_ADDR_WIDTH-1:0] dst_q;
    logic [SIZE_WIDTH-1:0]    size_q;
    logic                     done_q;
    logic                     start_q;

    // first access cycle decodes and the second answers and commits
    assign access  = apb_req_i.psel & apb_req_i.penable;
    assign decode  = access & ~pready_q;
    assign commit  = access & pready_q;
    assign ctrl_wr = commit & apb_req_i.pwrite & (apb_req_i.paddr == REG_CTRL);

    // read mux and address map
    always_comb begin
        hit     = 1'b1;
        rd_data = '0;
        case (apb_req_i.paddr)
            REG_SRC_ADDR: rd_data = src_q;
            REG_DST_ADDR: rd_data = dst_q;
            REG_SIZE:     rd_data = {{(L2_DATA_WIDTH-SIZE_WIDTH){1'b0}}, size_q};
            REG_CTRL:     rd_data = '0;
            REG_STATUS:   rd_data = {{(L2_DATA_WIDTH-2){1'b0}}, done_q | done_i, busy_i};
            default:      hit     = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= decode;
            pslverr_q <= decode & ~hit;
        end
    end

    // sampled in the decode cycle and valid with pready
    always_ff @(posedge sys_clk_i) begin
        if (decode) begin
            prdata_q <= rd_data;
        end
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_q  <= '0;
            dst_q  <= '0;
            size_q <= '0;
        end else if (commit && apb_req_i.pwrite) begin
            case (apb_req_i.paddr)
                REG_SRC_ADDR: src_q  <= apb_req_i.pwdata;
                REG_DST_ADDR: dst_q  <= apb_req_i.pwdata;
                REG_SIZE:     size_q <= apb_req_i.pwdata[SIZE_WIDTH-1:0];
                default:      ;
            endcase
        end
    end

    // start only from idle with a nonzero length
    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= ctrl_wr & apb_req_i.pwdata[0] & ~busy_i & (size_q != '0);
            if (done_i) begin
                done_q <= 1'b1;
            end else if (ctrl_wr) begin
                done_q <= 1'b0;
            end
        end
    end

    assign apb_rsp_o.prdata  = prdata_q;
    assign apb_rsp_o.pready  = pready_q;
    assign apb_rsp_o.pslverr = pslverr_q;

    assign cfg_o.src_addr = src_q;
    assign cfg_o.dst_addr = dst_q;
    assign cfg_o.words    = size_q;
    assign start_o        = start_q;

    assign evt_o.rsvd    = '0;
    assign evt_o.cfg_err = pslverr_q;
    assign evt_o.eot     = done_i;

endmodule

// ==== design/udma_xfer_fsm.sv ====
// copy sequencer: L2 read, data capture and L2 write, one word at a time
`timescale 1ns/100ps

module udma_xfer_fsm import udma_lite_pkg::*; (
    input  logic                     sys_clk_i,
    input  logic                     arst_n_i,
    input  logic                     start_i,
    input  logic [L2_ADDR_WIDTH-1:0] rd_addr_i,
    input  logic [L2_ADDR_WIDTH-1:0] wr_addr_i,
    input  logic                     last_i,
    output l2_rd_req_t               l2_rd_req_o,
    input  l2_rd_rsp_t               l2_rd_rsp_i,
    output l2_wr_req_t               l2_wr_req_o,
    input  logic                     l2_wr_gnt_i,
    output logic                     rd_step_o,
    output logic                     wr_step_o,
    output logic                     busy_o,
    output logic                     done_o
);

    xfer_state_e              state_q;
    xfer_state_e              state_d;
    logic [L2_DATA_WIDTH-1:0] data_q;
    logic                     done_q;

    // each state waits for its own handshake
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (start_i) state_d = RD_REQ;
            RD_REQ:
                if (l2_rd_rsp_i.gnt) state_d = RD_WAIT;
            RD_WAIT:
                if (l2_rd_rsp_i.rvalid) state_d = WR_REQ;
            WR_REQ:
                if (l2_wr_gnt_i) state_d = last_i ? IDLE : RD_REQ;
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= wr_step_o & last_i;
        end
    end

    // word buffer between the two ports
    always_ff @(posedge sys_clk_i) begin
        if (state_q == RD_WAIT && l2_rd_rsp_i.rvalid) begin
            data_q <= l2_rd_rsp_i.rdata;
        end
    end

    // requests held by state until granted
    assign l2_rd_req_o.req   = (state_q == RD_REQ);
    assign l2_rd_req_o.addr  = rd_addr_i;
    assign l2_wr_req_o.req   = (state_q == WR_REQ);
    assign l2_wr_req_o.addr  = wr_addr_i;
    assign l2_wr_req_o.wdata = data_q;

    assign rd_step_o = l2_rd_req_o.req & l2_rd_rsp_i.gnt;
    assign wr_step_o = l2_wr_req_o.req & l2_wr_gnt_i;
    assign busy_o    = (state_q != IDLE);
    assign done_o    = done_q;

endmodule

// ==== design/udma_xfer_counter.sv ====
// address and remaining word counters for the active copy
`timescale 1ns/100ps

module udma_xfer_counter import udma_lite_pkg::*; (
    input  logic                     sys_clk_i,
    input  logic                     arst_n_i,
    input  logic                     load_i,
    input  xfer_cfg_t                cfg_i,
    input  logic                     rd_step_i,
    input  logic                     wr_step_i,
    output logic [L2_ADDR_WIDTH-1:0] rd_addr_o,
    output logic [L2_ADDR_WIDTH-1:0] wr_addr_o,
    output logic                     last_o
);

    logic [L2_ADDR_WIDTH-1:0] rd_addr_q;
    logic [L2_ADDR_WIDTH-1:0] wr_addr_q;
    logic [SIZE_WIDTH-1:0]    remaining_q;

    // word count drops on each granted write
    always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            remaining_q <= '0;
        end else if (load_i) begin
            remaining_q <= cfg_i.words;
        end else if (wr_step_i) begin
            remaining_q <= remaining_q - SIZE_WIDTH'(1);
        end
    end

    // read and write pointers advance independently
    always_ff @(posedge sys_clk_i) begin
        if (load_i) begin
            rd_addr_q <= cfg_i.src_addr;
            wr_addr_q <= cfg_i.dst_addr;
        end else begin
            if (rd_step_i) begin
                rd_addr_q <= rd_addr_q + WORD_BYTES;
            end
            if (wr_step_i) begin
                wr_addr_q <= wr_addr_q + WORD_BYTES;
            end
        end
    end

    assign rd_addr_o = rd_addr_q;
    assign wr_addr_o = wr_addr_q;
    assign last_o    = (remaining_q == SIZE_WIDTH'(1));

endmodule

// ==== design/udma_lite.sv ====
// reduced udma top: APB registers, single memory to memory copy channel
`timescale 1ns/100ps

module udma_lite import udma_lite_pkg::*; (
    input  logic       sys_clk_i,
    input  logic       arst_n_i,
    input  apb_req_t   apb_req_i,
    output apb_rsp_t   apb_rsp_o,
    output l2_rd_req_t l2_rd_req_o,
    input  l2_rd_rsp_t l2_rd_rsp_i,
    output l2_wr_req_t l2_wr_req_o,
    input  logic       l2_wr_gnt_i,
    output udma_evt_t  evt_o
);

    xfer_cfg_t                s_cfg;
    logic                     s_start;
    logic                     s_busy;
    logic                     s_done;
    logic [L2_ADDR_WIDTH-1:0] s_rd_addr;
    logic [L2_ADDR_WIDTH-1:0] s_wr_addr;
    logic                     s_last;
    logic                     s_rd_step;
    logic                     s_wr_step;

    udma_cfg_regs i_cfg_regs (
        .sys_clk_i   ( sys_clk_i   ),
        .arst_n_i    ( arst_n_i    ),
        .apb_req_i   ( apb_req_i   ),
        .apb_rsp_o   ( apb_rsp_o   ),
        .busy_i      ( s_busy      ),
        .done_i      ( s_done      ),
        .cfg_o       ( s_cfg       ),
        .start_o     ( s_start     ),
        .evt_o       ( evt_o       )
    );

    udma_xfer_fsm i_xfer_fsm (
        .sys_clk_i   ( sys_clk_i   ),
        .arst_n_i    ( arst_n_i    ),
        .start_i     ( s_start     ),
        .rd_addr_i   ( s_rd_addr   ),
        .wr_addr_i   ( s_wr_addr   ),
        .last_i      ( s_last      ),
        .l2_rd_req_o ( l2_rd_req_o ),
        .l2_rd_rsp_i ( l2_rd_rsp_i ),
        .l2_wr_req_o ( l2_wr_req_o ),
        .l2_wr_gnt_i ( l2_wr_gnt_i ),
        .rd_step_o   ( s_rd_step   ),
        .wr_step_o   ( s_wr_step   ),
        .busy_o      ( s_busy      ),
        .done_o      ( s_done      )
    );

    // counters load on the same start pulse
    udma_xfer_counter i_xfer_counter (
        .sys_clk_i   ( sys_clk_i   ),
        .arst_n_i    ( arst_n_i    ),
        .load_i      ( s_start     ),
        .cfg_i       ( s_cfg       ),
        .rd_step_i   ( s_rd_step   ),
        .wr_step_i   ( s_wr_step   ),
        .rd_addr_o   ( s_rd_addr   ),
        .wr_addr_o   ( s_wr_addr   ),
        .last_o      ( s_last      )
    );

endmodule

// ==== sim/udma_lite_assertions.sv ====
// protocol checks on the udma lite ports: held requests, pready pulse, eot and busy
`timescale 1ns/100ps

module udma_lite_assertions import udma_lite_pkg::*; (
    input logic       sys_clk_i,
    input logic       arst_n_i,
    input apb_rsp_t   apb_rsp_i,
    input l2_rd_req_t l2_rd_req_i,
    input l2_rd_rsp_t l2_rd_rsp_i,
    input l2_wr_req_t l2_wr_req_i,
    input logic       l2_wr_gnt_i,
    input udma_evt_t  evt_i,
    input logic       busy_i
);

    // requests hold address and data until granted
    rd_req_held: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        l2_rd_req_i.req && !l2_rd_rsp_i.gnt |=> l2_rd_req_i.req && $stable(l2_rd_req_i.addr))
        else $error("read request dropped or changed before grant");

    wr_req_held: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        l2_wr_req_i.req && !l2_wr_gnt_i |=> l2_wr_req_i.req && $stable(l2_wr_req_i.addr)
        && $stable(l2_wr_req_i.wdata))
        else $error("write request dropped or changed before grant");

    pready_pulse: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        apb_rsp_i.pready |=> !apb_rsp_i.pready)
        else $error("pready high for more than one cycle");

    eot_pulse: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        evt_i.eot |=> !evt_i.eot)
        else $error("eot event longer than one cycle");

    // eot comes exactly when busy falls
    eot_when_idle: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        evt_i.eot |-> !busy_i)
        else $error("eot event while still busy");

    busy_end_eot: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
        $fell(busy_i) |-> evt_i.eot)
        else $error("busy fell without an eot event");

endmodule

bind udma_lite udma_lite_assertions i_udma_lite_assertions (
    .sys_clk_i   ( sys_clk_i   ),
    .arst_n_i    ( arst_n_i    ),
    .apb_rsp_i   ( apb_rsp_o   ),
    .l2_rd_req_i ( l2_rd_req_o ),
    .l2_rd_rsp_i ( l2_rd_rsp_i ),
    .l2_wr_req_i ( l2_wr_req_o ),
    .l2_wr_gnt_i ( l2_wr_gnt_i ),
    .evt_i       ( evt_o       ),
    .busy_i      ( s_busy      )
);

// ==== sim/tb_udma_lite.sv ====
// testbench for udma lite with APB stimulus, L2 memory model, reference copy and checks
`timescale 1ns/100ps

module tb_udma_lite import udma_lite_pkg::*; ();

    logic       sys_clk;
    logic       arst_n;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    l2_rd_req_t l2_rd_req;
    l2_rd_rsp_t l2_rd_rsp;
    l2_wr_req_t l2_wr_req;
    logic       l2_wr_gnt;
    udma_evt_t  evt;

    logic [31:0] mem [bit [31:0]];
    logic [31:0] exp_words [$];
    int          seed = 32'h06b7_9cff;
    int unsigned max_delay = 0;
    int          rd_delay = -1;
    int          wr_delay = -1;
    logic        rd_pending = 1'b0;
    logic [31:0] rd_addr;
    int unsigned wr_count = 0;
    int unsigned eot_count = 0;
    int unsigned cfg_err_count = 0;
    int unsigned errors = 0;
    int unsigned tests_passed = 0;
    int unsigned tests_failed = 0;

    udma_lite i_udma_lite (
        .sys_clk_i   ( sys_clk   ),
        .arst_n_i    ( arst_n    ),
        .apb_req_i   ( apb_req   ),
        .apb_rsp_o   ( apb_rsp   ),
        .l2_rd_req_o ( l2_rd_req ),
        .l2_rd_rsp_i ( l2_rd_rsp ),
        .l2_wr_req_o ( l2_wr_req ),
        .l2_wr_gnt_i ( l2_wr_gnt ),
        .evt_o       ( evt       )
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] mem_peek(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // unwritten words carry a pattern of their full address
        return {addr[15:0], addr[31:16]} ^ 32'ha5a5_c33c;
    endfunction

    // destination word idx is source word idx as it was before the copy
    function automatic logic [31:0] ref_copy_word(input logic [31:0] src, input int unsigned idx);
        return mem_peek(src + WORD_BYTES * idx);
    endfunction

    function automatic int pick_delay();
        if (max_delay == 0) begin
            return 0;
        end
        return int'($unsigned($random(seed)) % (max_delay + 1));
    endfunction

    // L2 model answering both ports from one process
    initial begin : l2_model
        forever begin
            @(negedge sys_clk);
            l2_rd_rsp.gnt    = 1'b0;
            l2_rd_rsp.rvalid = 1'b0;
            l2_wr_gnt        = 1'b0;
            if (rd_pending) begin
                // rvalid one cycle after the grant
                l2_rd_rsp.rvalid = 1'b1;
                l2_rd_rsp.rdata  = mem_peek(rd_addr);
                rd_pending       = 1'b0;
            end else if (l2_rd_req.req) begin
                if (rd_delay < 0) begin
                    rd_delay = pick_delay();
                end
                if (rd_delay == 0) begin
                    l2_rd_rsp.gnt = 1'b1;
                    rd_addr       = l2_rd_req.addr;
                    rd_pending    = 1'b1;
                end
                rd_delay--;
            end
            if (l2_wr_req.req) begin
                if (wr_delay < 0) begin
                    wr_delay = pick_delay();
                end
                if (wr_delay == 0) begin
                    l2_wr_gnt            = 1'b1;
                    mem[l2_wr_req.addr]  = l2_wr_req.wdata;
                    wr_count++;
                end
                wr_delay--;
            end
        end
    end

    always @(negedge sys_clk) begin
        if (evt.eot) begin
            eot_count++;
        end
        if (evt.cfg_err) begin
            cfg_err_count++;
        end
        compare_value("event reserved bits", 32'h0, evt.rsvd);
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic apb_access(input logic [11:0] addr, input logic write, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int unsigned waits;
        waits = 0;
        @(negedge sys_clk);
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pwrite  = write;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge sys_clk);
        apb_req.penable = 1'b1;
        @(negedge sys_clk);
        while (!apb_rsp.pready && waits < 8) begin
            @(negedge sys_clk);
            waits++;
        end
        if (!apb_rsp.pready) begin
            $display("APB access to offset %h never got pready", addr);
            errors++;
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        // hold through the commit edge and release after it
        @(negedge sys_clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(addr, 1'b1, wdata, rdata, slverr);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata);
        logic slverr;
        apb_access(addr, 1'b0, 32'h0, rdata, slverr);
    endtask

    task automatic load_source(input logic [31:0] src, input int unsigned words);
        exp_words.delete();
        for (int unsigned i = 0; i < words; i++) begin
            mem[src + WORD_BYTES * i] = $random(seed);
        end
        for (int unsigned i = 0; i < words; i++) begin
            exp_words.push_back(ref_copy_word(src, i));
        end
    endtask

    task automatic start_copy(input logic [31:0] src, input logic [31:0] dst,
                              input int unsigned words);
        apb_write(REG_SRC_ADDR, src);
        apb_write(REG_DST_ADDR, dst);
        apb_write(REG_SIZE, words);
        apb_write(REG_CTRL, 32'h1);
    endtask

    task automatic wait_eot(input int unsigned target, input int unsigned words);
        int unsigned cycles;
        cycles = 0;
        while (eot_count < target && cycles < words * 9 + 20) begin
            @(posedge sys_clk);
            cycles++;
        end
        if (eot_count < target) begin
            $display("copy of %0d words gave no end of transfer event in time", words);
            errors++;
        end
    endtask

    task automatic check_copy(input string name, input logic [31:0] src, input logic [31:0] dst,
                              input int unsigned words);
        for (int unsigned i = 0; i < words; i++) begin
            compare_value($sformatf("%s dst[%0d]", name, i), exp_words[i],
                          mem_peek(dst + WORD_BYTES * i));
            compare_value($sformatf("%s src[%0d]", name, i), exp_words[i],
                          mem_peek(src + WORD_BYTES * i));
        end
    endtask

    task automatic finish_test(input string name, input int unsigned errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    initial begin : main
        logic [31:0] rdata;
        logic        slverr;
        int unsigned errors_before;
        int unsigned eot_before;
        int unsigned wr_before;
        int unsigned cfg_before;
        apb_req   = '0;
        l2_rd_rsp = '0;
        l2_wr_gnt = 1'b0;
        arst_n    = 1'b0;
        repeat (8) @(posedge sys_clk);
        @(negedge sys_clk);
        arst_n = 1'b1;

        errors_before = errors;
        apb_read(REG_STATUS, rdata);
        compare_value("status after reset", 32'h0, rdata);
        apb_write(REG_SRC_ADDR, 32'h0000_1234);
        apb_write(REG_DST_ADDR, 32'h0000_5678);
        apb_write(REG_SIZE, 32'h0000_00a5);
        apb_read(REG_SRC_ADDR, rdata);
        compare_value("src readback", 32'h0000_1234, rdata);
        apb_read(REG_DST_ADDR, rdata);
        compare_value("dst readback", 32'h0000_5678, rdata);
        apb_read(REG_SIZE, rdata);
        compare_value("size readback", 32'h0000_00a5, rdata);
        apb_read(REG_CTRL, rdata);
        compare_value("ctrl readback", 32'h0, rdata);
        finish_test("register_access", errors_before);

        errors_before = errors;
        eot_before    = eot_count;
        load_source(32'h1000, 8);
        start_copy(32'h1000, 32'h2000, 8);
        wait_eot(eot_before + 1, 8);
        check_copy("copy_8", 32'h1000, 32'h2000, 8);
        finish_test("copy_8_words", errors_before);

        errors_before = errors;
        eot_before    = eot_count;
        load_source(32'h3000, 8);
        start_copy(32'h3000, 32'h3800, 8);
        apb_read(REG_STATUS, rdata);
        compare_value("status while busy", 32'h1, rdata);
        wait_eot(eot_before + 1, 8);
        repeat (4) @(negedge sys_clk);
        apb_read(REG_STATUS, rdata);
        compare_value("status after copy", 32'h2, rdata);
        compare_value("eot pulse count", eot_before + 1, eot_count);
        apb_write(REG_CTRL, 32'h0);
        apb_read(REG_STATUS, rdata);
        compare_value("status after done clear", 32'h0, rdata);
        check_copy("status_copy", 32'h3000, 32'h3800, 8);
        finish_test("status_and_eot", errors_before);

        // second start lands while the first copy runs
        errors_before = errors;
        max_delay     = 3;
        eot_before    = eot_count;
        wr_before     = wr_count;
        load_source(32'h5000, 8);
        start_copy(32'h5000, 32'h5800, 8);
        apb_write(REG_CTRL, 32'h1);
        wait_eot(eot_before + 1, 8);
        repeat (20) @(negedge sys_clk);
        compare_value("eot with start while busy", eot_before + 1, eot_count);
        compare_value("writes with start while busy", wr_before + 8, wr_count);
        check_copy("busy_start", 32'h5000, 32'h5800, 8);
        apb_write(REG_CTRL, 32'h0);
        apb_write(REG_SIZE, 32'h0);
        eot_before = eot_count;
        wr_before  = wr_count;
        apb_write(REG_CTRL, 32'h1);
        repeat (20) @(negedge sys_clk);
        compare_value("eot with zero size", eot_before, eot_count);
        compare_value("writes with zero size", wr_before, wr_count);
        apb_read(REG_STATUS, rdata);
        compare_value("status with zero size", 32'h0, rdata);
        finish_test("ignored_starts", errors_before);

        errors_before = errors;
        cfg_before    = cfg_err_count;
        apb_access(12'h014, 1'b1, 32'hdead_beef, rdata, slverr);
        compare_value("pslverr unmapped write", 32'h1, slverr);
        apb_access(12'h200, 1'b0, 32'h0, rdata, slverr);
        compare_value("pslverr unmapped read", 32'h1, slverr);
        apb_access(REG_SRC_ADDR, 1'b0, 32'h0, rdata, slverr);
        compare_value("pslverr mapped read", 32'h0, slverr);
        compare_value("src after unmapped", 32'h5000, rdata);
        apb_read(REG_DST_ADDR, rdata);
        compare_value("dst after unmapped", 32'h5800, rdata);
        apb_read(REG_SIZE, rdata);
        compare_value("size after unmapped", 32'h0, rdata);
        compare_value("cfg_err pulse count", cfg_before + 2, cfg_err_count);
        finish_test("unmapped_access", errors_before);

        errors_before = errors;
        eot_before    = eot_count;
        load_source(32'h8000, 32);
        start_copy(32'h8000, 32'hc000, 32);
        wait_eot(eot_before + 1, 32);
        check_copy("copy_32", 32'h8000, 32'hc000, 32);
        finish_test("copy_32_random_grants", errors_before);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        int unsigned limit;
        // worst word is 4 cycles to read grant, 1 to rvalid, 4 to write grant
        limit = (8 + 8 + 8 + 32) * 9 + 800;
        repeat (limit) @(posedge sys_clk);
        $display("timeout: run still going after %0d clock cycles", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== src.f ====
design/udma_lite_pkg.sv
design/udma_cfg_regs.sv
design/udma_xfer_fsm.sv
design/udma_xfer_counter.sv
design/udma_lite.sv
sim/udma_lite_assertions.sv
sim/tb_udma_lite.sv

// ==== Bender.yml ====
package:
  name: udma_lite

sources:
  - design/udma_lite_pkg.sv
  - design/udma_cfg_regs.sv
  - design/udma_xfer_fsm.sv
  - design/udma_xfer_counter.sv
  - design/udma_lite.sv
  - target: simulation
    files:
      - sim/udma_lite_assertions.sv
      - sim/tb_udma_lite.sv
